//--- files.f
logic/backend_pkg.sv
logic/stage_reg.sv
logic/issue_buffer.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/retire_stage.sv
logic/dual_backend.sv
bench/clk_gen.sv
bench/backend_checker.sv
bench/backend_sva.sv
bench/tb_dual_backend.sv

//--- bench/tb_dual_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dual_backend import backend_pkg::*; ();

    localparam int IBUF_DEPTH = 4;
    localparam int RCREDITS   = 2;
    localparam int DMEM_WORDS = 64;
    localparam int RUN_CYCLES = 2000;
    localparam int WAIT_LIMIT = 400;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    logic               in_m_valid;
    op_t                in_m_op;
    logic [XLEN-1:0]    in_m_src_a;
    logic [XLEN-1:0]    in_m_src_b;
    logic [RADDR_W-1:0] in_m_dest;
    logic [XLEN-1:0]    in_m_pc;
    logic               in_s_valid;
    op_t                in_s_op;
    logic [XLEN-1:0]    in_s_src_a;
    logic [XLEN-1:0]    in_s_src_b;
    logic [RADDR_W-1:0] in_s_dest;
    logic [XLEN-1:0]    in_s_pc;
    logic               issue_credit;
    logic               retire_credit;
    logic               retire_valid;
    logic               ret_m_valid;
    logic [RADDR_W-1:0] ret_m_dest;
    logic               ret_m_wen;
    logic [XLEN-1:0]    ret_m_value;
    logic [XLEN-1:0]    ret_m_pc;
    logic               ret_s_valid;
    logic [RADDR_W-1:0] ret_s_dest;
    logic               ret_s_wen;
    logic [XLEN-1:0]    ret_s_value;
    logic [XLEN-1:0]    ret_s_pc;
    int                 err_count;
    int                 retired;
    int                 pairs_issued;
    int                 credit_pulses;
    int                 pending;

    int                 issuer_credits;
    int                 rc_out;        // Retire credits held by the DUT
    int                 grant_pct;
    int                 tb_errors;
    int                 total_errors;
    logic [XLEN-1:0]    next_pc;
    logic               rv_seen;
    int                 rates [4] = '{0, 10, 50, 100};

    clk_gen u_clk (.clk, .rst_n);

    dual_backend #(
        .IBUF_DEPTH(IBUF_DEPTH), .RCREDITS(RCREDITS), .DMEM_WORDS(DMEM_WORDS)
    ) u_dut (.*);

    backend_checker #(.DMEM_WORDS(DMEM_WORDS)) u_chk (.*);

    // One clock; credits follow the values the DUT saw on this edge
    task automatic step_cycle();
        @(posedge clk);
        issuer_credits += int'(issue_credit);
        rc_out += int'(retire_credit) - int'(retire_valid);
        rv_seen = retire_valid;
        #1;
    endtask

    task automatic drive_random_pair(input logic force_m);
        in_valid   = 1'b1;
        in_m_valid = force_m | ($urandom_range(7) != 0);
        in_m_op    = op_t'($urandom_range(5));
        in_m_src_a = (in_m_op == OP_LW || in_m_op == OP_SW) ? ($urandom_range(7) << 2) : $urandom;
        in_m_src_b = $urandom;
        in_m_dest  = RADDR_W'($urandom);
        in_m_pc    = next_pc;
        in_s_valid = ($urandom_range(7) != 0);
        in_s_op    = op_t'($urandom_range(3));  // ALU ops only
        in_s_src_a = $urandom;
        in_s_src_b = $urandom;
        in_s_dest  = RADDR_W'($urandom);
        in_s_pc    = next_pc + 4;
        next_pc    = next_pc + 8;
        issuer_credits--;
    endtask

    task automatic grant_credit(input int pct);
        retire_credit = (rc_out < RCREDITS) && ($urandom_range(99) < pct);
    endtask

    task automatic wait_drained();
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            step_cycle();
            in_valid = 1'b0;
            grant_credit(100);
            if (issuer_credits == IBUF_DEPTH && pending == 0)
                break;
        end
        if (n == WAIT_LIMIT) begin
            tb_errors++;
            $display("Timeout: pipeline did not drain, %0d pairs still pending", pending);
        end
    endtask

    task automatic measure_latency();
        int n;
        for (n = 0; n < WAIT_LIMIT && rc_out < RCREDITS; n++) begin
            step_cycle();
            grant_credit(100);
        end
        if (rc_out < RCREDITS) begin
            tb_errors++;
            $display("Timeout: retire credits were never refilled before the latency test");
        end
        retire_credit = 1'b0;
        drive_random_pair(1'b1);
        step_cycle();  // in_valid taken on this edge
        in_valid = 1'b0;
        for (n = 1; n <= 20; n++) begin
            step_cycle();
            if (rv_seen)
                break;
        end
        if (n > 20) begin
            tb_errors++;
            $display("Timeout: single pair never retired in the latency test");
        end else if (n != 3) begin
            tb_errors++;
            $display("Error at %0t: retire_valid latency got %0d expected %0d", $time, n, 3);
        end
    endtask

    initial begin
        int cyc;
        in_valid      = 1'b0;
        in_m_valid    = 1'b0;
        in_m_op       = OP_ADD;
        in_m_src_a    = '0;
        in_m_src_b    = '0;
        in_m_dest     = '0;
        in_m_pc       = '0;
        in_s_valid    = 1'b0;
        in_s_op       = OP_ADD;
        in_s_src_a    = '0;
        in_s_src_b    = '0;
        in_s_dest     = '0;
        in_s_pc       = '0;
        retire_credit = 1'b0;
        void'($urandom(99775));
        issuer_credits = IBUF_DEPTH;
        rc_out         = 0;
        tb_errors      = 0;
        grant_pct      = 100;
        next_pc        = 32'h0000_1000;

        for (cyc = 0; cyc < 20 && rst_n !== 1'b1; cyc++)
            @(posedge clk);
        if (rst_n !== 1'b1) begin
            tb_errors++;
            $display("Timeout: reset was never released");
        end
        #1;

        // Random traffic with credit starvation phases
        for (cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            step_cycle();
            if (cyc % 64 == 0)
                grant_pct = rates[$urandom_range(3)];
            in_valid = 1'b0;
            if (issuer_credits > 0 && $urandom_range(3) != 0)
                drive_random_pair(1'b0);
            grant_credit(grant_pct);
        end

        wait_drained();
        measure_latency();
        wait_drained();

        if (issuer_credits != IBUF_DEPTH) begin
            tb_errors++;
            $display("Error at %0t: issuer credits got %0d expected %0d", $time,
                     issuer_credits, IBUF_DEPTH);
        end
        if (credit_pulses != pairs_issued) begin
            tb_errors++;
            $display("Error at %0t: issue_credit pulses got %0d expected %0d", $time,
                     credit_pulses, pairs_issued);
        end

        total_errors = err_count + tb_errors + u_dut.u_sva.fails;
        $display("Retired %0d of %0d issued pairs: %0d checker, %0d testbench, %0d assertion errors",
                 retired, pairs_issued, err_count, tb_errors, u_dut.u_sva.fails);
        if (total_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/backend_sva.sv
`timescale 1ns/1ps
`default_nettype none

module backend_sva #(
    parameter int IBUF_DEPTH = 4,
    parameter int RCREDITS   = 2
) (
    input logic                            clk,
    input logic                            rst_n,
    input logic [$clog2(RCREDITS+1)-1:0]   credit_cnt,
    input logic [$clog2(IBUF_DEPTH+1)-1:0] ibuf_count,
    input logic                            push,
    input logic                            issue_credit,
    input logic                            clr_ex_m,
    input logic                            clr_ex_s,
    input logic                            clr_wb_m,
    input logic                            clr_wb_s,
    input logic                            mem_m_valid,
    input logic                            mem_s_valid,
    input logic                            wb_q_m_valid,
    input logic                            wb_q_s_valid
);

    int fails = 0;

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n) credit_cnt <= RCREDITS)
        else begin fails++; $error("retire credit count above limit"); end

    no_full_push: assert property (@(posedge clk) disable iff (!rst_n)
                                   push |-> ibuf_count < IBUF_DEPTH)
        else begin fails++; $error("push into a full issue buffer"); end

    // A credit means an entry was really freed
    credit_on_pop: assert property (@(posedge clk) disable iff (!rst_n)
                                    issue_credit |=>
                                    ibuf_count == $past(ibuf_count) + $past(push) - 1)
        else begin fails++; $error("issue_credit without an entry leaving the buffer"); end

    ex_m_bubble: assert property (@(posedge clk) disable iff (!rst_n) clr_ex_m |=> !mem_m_valid)
        else begin fails++; $error("cleared ex/mem master lane still valid"); end

    ex_s_bubble: assert property (@(posedge clk) disable iff (!rst_n) clr_ex_s |=> !mem_s_valid)
        else begin fails++; $error("cleared ex/mem slave lane still valid"); end

    wb_m_bubble: assert property (@(posedge clk) disable iff (!rst_n) clr_wb_m |=> !wb_q_m_valid)
        else begin fails++; $error("cleared mem/wb master lane still valid"); end

    wb_s_bubble: assert property (@(posedge clk) disable iff (!rst_n) clr_wb_s |=> !wb_q_s_valid)
        else begin fails++; $error("cleared mem/wb slave lane still valid"); end

endmodule

bind dual_backend backend_sva #(.IBUF_DEPTH(IBUF_DEPTH), .RCREDITS(RCREDITS)) u_sva (
    .clk, .rst_n,
    .credit_cnt(u_retire.credit_cnt),
    .ibuf_count(u_ibuf.count),
    .push(in_valid),
    .issue_credit,
    .clr_ex_m, .clr_ex_s, .clr_wb_m, .clr_wb_s,
    .mem_m_valid(mem_m.valid),
    .mem_s_valid(mem_s.valid),
    .wb_q_m_valid(wb_q_m.valid),
    .wb_q_s_valid(wb_q_s.valid)
);

`default_nettype wire

//--- bench/backend_checker.sv
`timescale 1ns/1ps
`default_nettype none

module backend_checker import backend_pkg::*; #(
    parameter int DMEM_WORDS = 64
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  logic               in_m_valid,
    input  op_t                in_m_op,
    input  logic [XLEN-1:0]    in_m_src_a,
    input  logic [XLEN-1:0]    in_m_src_b,
    input  logic [RADDR_W-1:0] in_m_dest,
    input  logic [XLEN-1:0]    in_m_pc,
    input  logic               in_s_valid,
    input  op_t                in_s_op,
    input  logic [XLEN-1:0]    in_s_src_a,
    input  logic [XLEN-1:0]    in_s_src_b,
    input  logic [RADDR_W-1:0] in_s_dest,
    input  logic [XLEN-1:0]    in_s_pc,
    input  logic               issue_credit,
    input  logic               retire_credit,
    input  logic               retire_valid,
    input  logic               ret_m_valid,
    input  logic [RADDR_W-1:0] ret_m_dest,
    input  logic               ret_m_wen,
    input  logic [XLEN-1:0]    ret_m_value,
    input  logic [XLEN-1:0]    ret_m_pc,
    input  logic               ret_s_valid,
    input  logic [RADDR_W-1:0] ret_s_dest,
    input  logic               ret_s_wen,
    input  logic [XLEN-1:0]    ret_s_value,
    input  logic [XLEN-1:0]    ret_s_pc,
    output int                 err_count,
    output int                 retired,
    output int                 pairs_issued,
    output int                 credit_pulses,
    output int                 pending
);

    typedef struct packed {
        logic               m_valid;
        logic [RADDR_W-1:0] m_dest;
        logic               m_wen;
        logic [XLEN-1:0]    m_value;
        logic [XLEN-1:0]    m_pc;
        logic               s_valid;
        logic [RADDR_W-1:0] s_dest;
        logic               s_wen;
        logic [XLEN-1:0]    s_value;
        logic [XLEN-1:0]    s_pc;
    } retire_t;

    retire_t         exp_q [$];
    logic [XLEN-1:0] model_mem [int];  // Only words that were stored
    int              held;

    function automatic logic [XLEN-1:0] alu_model(input op_t op, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] want);
        if (got !== want) begin
            err_count++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    always @(posedge clk) begin
        retire_t nxt;
        retire_t want;
        int      idx;
        if (!rst_n) begin
            held = 0;
        end else begin
            if (issue_credit)
                credit_pulses++;
            if (in_valid) begin
                pairs_issued++;
                nxt = '0;  // Invalid lanes retire as all zeros
                if (in_m_valid) begin
                    nxt.m_valid = 1'b1;
                    nxt.m_dest  = in_m_dest;
                    nxt.m_pc    = in_m_pc;
                    nxt.m_wen   = (in_m_op != OP_SW);
                    idx         = int'((in_m_src_a >> 2) % DMEM_WORDS);
                    case (in_m_op)
                        OP_LW:   nxt.m_value = model_mem.exists(idx) ? model_mem[idx] : '0;
                        OP_SW: begin
                            nxt.m_value    = in_m_src_a;  // Address passes through
                            model_mem[idx] = in_m_src_b;
                        end
                        default: nxt.m_value = alu_model(in_m_op, in_m_src_a, in_m_src_b);
                    endcase
                end
                if (in_s_valid) begin
                    nxt.s_valid = 1'b1;
                    nxt.s_dest  = in_s_dest;
                    nxt.s_pc    = in_s_pc;
                    nxt.s_wen   = 1'b1;
                    nxt.s_value = alu_model(in_s_op, in_s_src_a, in_s_src_b);
                end
                if (nxt.m_valid || nxt.s_valid)
                    exp_q.push_back(nxt);
            end
            if (retire_valid) begin
                if (held == 0) begin
                    err_count++;
                    $display("Error at %0t: retire_valid asserted with no credit held", $time);
                end
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("Error at %0t: retire_valid with no pair outstanding", $time);
                end else begin
                    want = exp_q.pop_front();
                    retired++;
                    compare_field("ret_m_valid", ret_m_valid, want.m_valid);
                    compare_field("ret_m_dest", ret_m_dest, want.m_dest);
                    compare_field("ret_m_wen", ret_m_wen, want.m_wen);
                    compare_field("ret_m_value", ret_m_value, want.m_value);
                    compare_field("ret_m_pc", ret_m_pc, want.m_pc);
                    compare_field("ret_s_valid", ret_s_valid, want.s_valid);
                    compare_field("ret_s_dest", ret_s_dest, want.s_dest);
                    compare_field("ret_s_wen", ret_s_wen, want.s_wen);
                    compare_field("ret_s_value", ret_s_value, want.s_value);
                    compare_field("ret_s_pc", ret_s_pc, want.s_pc);
                end
            end
            held = held + int'(retire_credit) - int'(retire_valid);
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

//--- bench/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;  // Released in step with the other stimulus
    end

endmodule

`default_nettype wire

//--- logic/dual_backend.sv
`timescale 1ns/1ps
`default_nettype none

module dual_backend import backend_pkg::*; #(
    parameter int IBUF_DEPTH = 4,
    parameter int RCREDITS   = 2,
    parameter int DMEM_WORDS = 64
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  logic               in_m_valid,
    input  op_t                in_m_op,
    input  logic [XLEN-1:0]    in_m_src_a,
    input  logic [XLEN-1:0]    in_m_src_b,
    input  logic [RADDR_W-1:0] in_m_dest,
    input  logic [XLEN-1:0]    in_m_pc,
    input  logic               in_s_valid,
    input  op_t                in_s_op,
    input  logic [XLEN-1:0]    in_s_src_a,
    input  logic [XLEN-1:0]    in_s_src_b,
    input  logic [RADDR_W-1:0] in_s_dest,
    input  logic [XLEN-1:0]    in_s_pc,
    output logic               issue_credit,
    input  logic               retire_credit,
    output logic               retire_valid,
    output logic               ret_m_valid,
    output logic [RADDR_W-1:0] ret_m_dest,
    output logic               ret_m_wen,
    output logic [XLEN-1:0]    ret_m_value,
    output logic [XLEN-1:0]    ret_m_pc,
    output logic               ret_s_valid,
    output logic [RADDR_W-1:0] ret_s_dest,
    output logic               ret_s_wen,
    output logic [XLEN-1:0]    ret_s_value,
    output logic [XLEN-1:0]    ret_s_pc
);

    logic               advance;
    logic               head_valid;
    logic               head_m_valid;
    op_t                head_m_op;
    logic [XLEN-1:0]    head_m_src_a;
    logic [XLEN-1:0]    head_m_src_b;
    logic [RADDR_W-1:0] head_m_dest;
    logic [XLEN-1:0]    head_m_pc;
    logic               head_s_valid;
    op_t                head_s_op;
    logic [XLEN-1:0]    head_s_src_a;
    logic [XLEN-1:0]    head_s_src_b;
    logic [RADDR_W-1:0] head_s_dest;
    logic [XLEN-1:0]    head_s_pc;
    ex_lane_t           ex_m;
    ex_lane_t           ex_s;
    ex_lane_t           mem_m;
    ex_lane_t           mem_s;
    wb_lane_t           wb_m;
    wb_lane_t           wb_s;
    wb_lane_t           wb_q_m;
    wb_lane_t           wb_q_s;
    logic               clr_ex_m;
    logic               clr_ex_s;
    logic               clr_wb_m;
    logic               clr_wb_s;

    // Invalid lanes enter as cleared bubbles
    assign clr_ex_m = advance & ~ex_m.valid;
    assign clr_ex_s = advance & ~ex_s.valid;
    assign clr_wb_m = advance & ~wb_m.valid;
    assign clr_wb_s = advance & ~wb_s.valid;

    issue_buffer #(.IBUF_DEPTH(IBUF_DEPTH)) u_ibuf (
        .clk, .rst_n, .push(in_valid),
        .in_m_valid, .in_m_op, .in_m_src_a, .in_m_src_b, .in_m_dest, .in_m_pc,
        .in_s_valid, .in_s_op, .in_s_src_a, .in_s_src_b, .in_s_dest, .in_s_pc,
        .pop(advance), .head_valid,
        .head_m_valid, .head_m_op, .head_m_src_a, .head_m_src_b, .head_m_dest, .head_m_pc,
        .head_s_valid, .head_s_op, .head_s_src_a, .head_s_src_b, .head_s_dest, .head_s_pc,
        .issue_credit
    );

    execute_stage u_exec (
        .head_valid,
        .head_m_valid, .head_m_op, .head_m_src_a, .head_m_src_b, .head_m_dest, .head_m_pc,
        .head_s_valid, .head_s_op, .head_s_src_a, .head_s_src_b, .head_s_dest, .head_s_pc,
        .ex_m, .ex_s
    );

    stage_reg #(.lane_t(ex_lane_t)) u_ex_mem (
        .clk, .rst_n, .ena_m(advance), .ena_s(advance),
        .clear_m(clr_ex_m), .clear_s(clr_ex_s),
        .d_m(ex_m), .d_s(ex_s), .q_m(mem_m), .q_s(mem_s)
    );

    memory_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem (
        .clk, .rst_n, .advance, .mem_m, .mem_s, .wb_m, .wb_s
    );

    stage_reg #(.lane_t(wb_lane_t)) u_mem_wb (
        .clk, .rst_n, .ena_m(advance), .ena_s(advance),
        .clear_m(clr_wb_m), .clear_s(clr_wb_s),
        .d_m(wb_m), .d_s(wb_s), .q_m(wb_q_m), .q_s(wb_q_s)
    );

    retire_stage #(.RCREDITS(RCREDITS)) u_retire (
        .clk, .rst_n, .retire_credit, .wb_q_m, .wb_q_s, .advance, .retire_valid,
        .ret_m_valid, .ret_m_dest, .ret_m_wen, .ret_m_value, .ret_m_pc,
        .ret_s_valid, .ret_s_dest, .ret_s_wen, .ret_s_value, .ret_s_pc
    );

endmodule

`default_nettype wire

//--- logic/retire_stage.sv
`timescale 1ns/1ps
`default_nettype none

module retire_stage import backend_pkg::*; #(
    parameter int RCREDITS = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               retire_credit,
    input  wb_lane_t           wb_q_m,
    input  wb_lane_t           wb_q_s,
    output logic               advance,
    output logic               retire_valid,
    output logic               ret_m_valid,
    output logic [RADDR_W-1:0] ret_m_dest,
    output logic               ret_m_wen,
    output logic [XLEN-1:0]    ret_m_value,
    output logic [XLEN-1:0]    ret_m_pc,
    output logic               ret_s_valid,
    output logic [RADDR_W-1:0] ret_s_dest,
    output logic               ret_s_wen,
    output logic [XLEN-1:0]    ret_s_value,
    output logic [XLEN-1:0]    ret_s_pc
);

    localparam int CNT_W = $clog2(RCREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;
    logic             credit_held;
    logic             pair_valid;

    assign credit_held = (credit_cnt != '0);
    // A pair with both lanes invalid was squashed to a bubble earlier
    assign pair_valid   = wb_q_m.valid | wb_q_s.valid;
    assign retire_valid = pair_valid & credit_held;
    assign advance      = ~pair_valid | credit_held;  // Stall only on a held pair

    always_ff @(posedge clk) begin
        if (!rst_n)
            credit_cnt <= '0;
        else
            credit_cnt <= credit_cnt + CNT_W'(retire_credit) - CNT_W'(retire_valid);
    end

    assign ret_m_valid = wb_q_m.valid;
    assign ret_m_dest  = wb_q_m.dest;
    assign ret_m_wen   = wb_q_m.reg_wen;
    assign ret_m_value = wb_q_m.value;
    assign ret_m_pc    = wb_q_m.pc;

    assign ret_s_valid = wb_q_s.valid;
    assign ret_s_dest  = wb_q_s.dest;
    assign ret_s_wen   = wb_q_s.reg_wen;
    assign ret_s_value = wb_q_s.value;
    assign ret_s_pc    = wb_q_s.pc;

endmodule

`default_nettype wire

//--- logic/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage import backend_pkg::*; #(
    parameter int DMEM_WORDS = 64
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     advance,
    input  ex_lane_t mem_m,
    input  ex_lane_t mem_s,
    output wb_lane_t wb_m,
    output wb_lane_t wb_s
);

    localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    logic [XLEN-1:0]       dmem [DMEM_WORDS];
    logic [DMEM_WORDS-1:0] written;  // Words never written read as 0
    logic [IDX_W-1:0]      idx;
    logic                  is_load;
    logic                  is_store;
    logic [XLEN-1:0]       rd_word;

    assign idx      = IDX_W'((mem_m.result >> 2) % DMEM_WORDS);
    assign is_load  = mem_m.valid && (mem_m.op == OP_LW);
    assign is_store = mem_m.valid && (mem_m.op == OP_SW);

    always_ff @(posedge clk) begin
        if (advance && is_store)
            dmem[idx] <= mem_m.store_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            written <= '0;
        else if (advance && is_store)
            written[idx] <= 1'b1;
    end

    // Read data is captured by mem/wb on the same advance edge
    assign rd_word = written[idx] ? dmem[idx] : '0;

    always_comb begin
        wb_m.valid   = mem_m.valid;
        wb_m.dest    = mem_m.dest;
        wb_m.reg_wen = mem_m.reg_wen;
        wb_m.value   = is_load ? rd_word : mem_m.result;
        wb_m.pc      = mem_m.pc;
    end

    always_comb begin
        wb_s.valid   = mem_s.valid;
        wb_s.dest    = mem_s.dest;
        wb_s.reg_wen = mem_s.reg_wen;
        wb_s.value   = mem_s.result;  // ALU only
        wb_s.pc      = mem_s.pc;
    end

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import backend_pkg::*; (
    input  logic               head_valid,
    input  logic               head_m_valid,
    input  op_t                head_m_op,
    input  logic [XLEN-1:0]    head_m_src_a,
    input  logic [XLEN-1:0]    head_m_src_b,
    input  logic [RADDR_W-1:0] head_m_dest,
    input  logic [XLEN-1:0]    head_m_pc,
    input  logic               head_s_valid,
    input  op_t                head_s_op,
    input  logic [XLEN-1:0]    head_s_src_a,
    input  logic [XLEN-1:0]    head_s_src_b,
    input  logic [RADDR_W-1:0] head_s_dest,
    input  logic [XLEN-1:0]    head_s_pc,
    output ex_lane_t           ex_m,
    output ex_lane_t           ex_s
);

    function automatic logic [XLEN-1:0] alu(input op_t op, input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            default: return a;  // Loads and stores address through src_a
        endcase
    endfunction

    function automatic ex_lane_t make_lane(input logic valid, input op_t op,
                                           input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                                           input logic [RADDR_W-1:0] dest,
                                           input logic [XLEN-1:0] pc);
        ex_lane_t lane;
        lane.valid      = valid;
        lane.op         = op;
        lane.dest       = dest;
        lane.reg_wen    = (op != OP_SW);
        lane.result     = alu(op, a, b);
        lane.store_data = b;
        lane.pc         = pc;
        return lane;
    endfunction

    // Empty buffer turns both lanes into bubbles
    assign ex_m = make_lane(head_valid & head_m_valid, head_m_op, head_m_src_a, head_m_src_b,
                            head_m_dest, head_m_pc);
    assign ex_s = make_lane(head_valid & head_s_valid, head_s_op, head_s_src_a, head_s_src_b,
                            head_s_dest, head_s_pc);

endmodule

`default_nettype wire

//--- logic/issue_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module issue_buffer import backend_pkg::*; #(
    parameter int IBUF_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  logic               in_m_valid,
    input  op_t                in_m_op,
    input  logic [XLEN-1:0]    in_m_src_a,
    input  logic [XLEN-1:0]    in_m_src_b,
    input  logic [RADDR_W-1:0] in_m_dest,
    input  logic [XLEN-1:0]    in_m_pc,
    input  logic               in_s_valid,
    input  op_t                in_s_op,
    input  logic [XLEN-1:0]    in_s_src_a,
    input  logic [XLEN-1:0]    in_s_src_b,
    input  logic [RADDR_W-1:0] in_s_dest,
    input  logic [XLEN-1:0]    in_s_pc,
    input  logic               pop,
    output logic               head_valid,
    output logic               head_m_valid,
    output op_t                head_m_op,
    output logic [XLEN-1:0]    head_m_src_a,
    output logic [XLEN-1:0]    head_m_src_b,
    output logic [RADDR_W-1:0] head_m_dest,
    output logic [XLEN-1:0]    head_m_pc,
    output logic               head_s_valid,
    output op_t                head_s_op,
    output logic [XLEN-1:0]    head_s_src_a,
    output logic [XLEN-1:0]    head_s_src_b,
    output logic [RADDR_W-1:0] head_s_dest,
    output logic [XLEN-1:0]    head_s_pc,
    output logic               issue_credit
);

    localparam int PTR_W = (IBUF_DEPTH > 1) ? $clog2(IBUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(IBUF_DEPTH + 1);

    typedef struct packed {
        logic               valid;
        op_t                op;
        logic [XLEN-1:0]    src_a;
        logic [XLEN-1:0]    src_b;
        logic [RADDR_W-1:0] dest;
        logic [XLEN-1:0]    pc;
    } slot_t;

    slot_t            slots_m [IBUF_DEPTH];
    slot_t            slots_s [IBUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(IBUF_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_valid   = (count != '0);
    assign do_pop       = pop & head_valid;
    assign issue_credit = do_pop;  // One credit back per entry freed

    always_ff @(posedge clk) begin
        if (push) begin
            slots_m[wr_ptr] <= '{in_m_valid, in_m_op, in_m_src_a, in_m_src_b, in_m_dest, in_m_pc};
            slots_s[wr_ptr] <= '{in_s_valid, in_s_op, in_s_src_a, in_s_src_b, in_s_dest, in_s_pc};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            count <= count + CNT_W'(push) - CNT_W'(do_pop);
        end
    end

    assign head_m_valid = slots_m[rd_ptr].valid;
    assign head_m_op    = slots_m[rd_ptr].op;
    assign head_m_src_a = slots_m[rd_ptr].src_a;
    assign head_m_src_b = slots_m[rd_ptr].src_b;
    assign head_m_dest  = slots_m[rd_ptr].dest;
    assign head_m_pc    = slots_m[rd_ptr].pc;

    assign head_s_valid = slots_s[rd_ptr].valid;
    assign head_s_op    = slots_s[rd_ptr].op;
    assign head_s_src_a = slots_s[rd_ptr].src_a;
    assign head_s_src_b = slots_s[rd_ptr].src_b;
    assign head_s_dest  = slots_s[rd_ptr].dest;
    assign head_s_pc    = slots_s[rd_ptr].pc;

endmodule

`default_nettype wire

//--- logic/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type lane_t = logic
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  ena_m,
    input  logic  ena_s,
    input  logic  clear_m,
    input  logic  clear_s,
    input  lane_t d_m,
    input  lane_t d_s,
    output lane_t q_m,
    output lane_t q_s
);

    // All zeros is an invalid lane
    always_ff @(posedge clk) begin
        if (!rst_n || clear_m) begin
            q_m <= '0;
        end else if (ena_m) begin
            q_m <= d_m;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear_s) begin
            q_s <= '0;
        end else if (ena_s) begin
            q_s <= d_s;
        end
    end

endmodule

`default_nettype wire

//--- logic/backend_pkg.sv
`default_nettype none

package backend_pkg;

    localparam int XLEN    = 32;
    localparam int RADDR_W = 5;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_LW  = 3'd4,
        OP_SW  = 3'd5
    } op_t;

    typedef struct packed {
        logic               valid;
        op_t                op;
        logic [RADDR_W-1:0] dest;
        logic               reg_wen;
        logic [XLEN-1:0]    result;     // ALU result or memory address
        logic [XLEN-1:0]    store_data;
        logic [XLEN-1:0]    pc;
    } ex_lane_t;

    typedef struct packed {
        logic               valid;
        logic [RADDR_W-1:0] dest;
        logic               reg_wen;
        logic [XLEN-1:0]    value;
        logic [XLEN-1:0]    pc;
    } wb_lane_t;

endpackage

`default_nettype wire
